// File: design/fb_config_regs.sv
module fb_config_regs (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                cfg_we,
    input  fb_pkg::cfg_addr_t   cfg_addr,
    input  fb_pkg::screen_pos_t cfg_wdata,
    input  logic                frame_start,
    output fb_pkg::fb_cfg_t     cfg
);

    fb_pkg::fb_cfg_t staged;
    fb_pkg::fb_cfg_t shadow;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            staged <= '{src: fb_pkg::SRC_FRAME, sq_row: '0, sq_col: '0};
            shadow <= '{src: fb_pkg::SRC_FRAME, sq_row: '0, sq_col: '0};
        end else begin
            if (cfg_we) begin
                case (cfg_addr)
                    fb_pkg::CFG_SRC:    staged.src    <= fb_pkg::display_src_t'(cfg_wdata[1:0]);
                    fb_pkg::CFG_SQ_ROW: staged.sq_row <= cfg_wdata;
                    fb_pkg::CFG_SQ_COL: staged.sq_col <= cfg_wdata;
                    default: ;
                endcase
            end
            if (frame_start) begin
                shadow <= staged;
            end
        end
    end

    // new settings already cover the first pixel of the frame
    assign cfg = frame_start ? staged : shadow;

endmodule

// File: design/fb_pixel_writer.sv
module fb_pixel_writer #(
    parameter int H_ACTIVE = 640,
    parameter int CREDITS  = 4
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                pix_valid,
    input  fb_pkg::pixel_xfer_t pix,
    input  logic                wr_gnt,
    output logic                pix_credit,
    output logic                wr_req,
    output fb_pkg::sram_addr_t  wr_addr,
    output fb_pkg::sram_word_t  wr_data,
    output logic [1:0]          wr_be
);

    localparam int PW = (CREDITS > 1) ? $clog2(CREDITS) : 1;
    localparam int CW = $clog2(CREDITS + 1);

    fb_pkg::pixel_xfer_t queue [CREDITS];
    fb_pkg::pixel_xfer_t cur;
    fb_pkg::wr_state_t   state;
    fb_pkg::sram_addr_t  base;
    logic [PW-1:0]       head;
    logic [PW-1:0]       tail;
    logic [CW-1:0]       count;
    logic                pop;

    // rows must start on a whole pixel pair, i.e. a three-word boundary
    if (H_ACTIVE % 2 != 0) begin : g_width_check
        $error("fb_pixel_writer: H_ACTIVE must be even");
    end

    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
        return (p == PW'(CREDITS - 1)) ? '0 : p + 1'b1;
    endfunction

    assign cur    = queue[head];
    assign pop    = (state == fb_pkg::WR_SECOND) && wr_gnt;
    assign wr_req = (state != fb_pkg::WR_IDLE);
    // p + p/2 halfwords per pixel pair
    assign base   = fb_pkg::sram_addr_t'(cur.id) + fb_pkg::sram_addr_t'(cur.id >> 1);

    always_ff @(posedge clk) begin
        if (pix_valid) begin
            queue[tail] <= pix;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head       <= '0;
            tail       <= '0;
            count      <= '0;
            state      <= fb_pkg::WR_IDLE;
            pix_credit <= 1'b0;
        end else begin
            // credit goes back once the head pixel is fully in sram
            pix_credit <= pop;
            if (pix_valid) begin
                tail <= next_ptr(tail);
            end
            if (pop) begin
                head <= next_ptr(head);
            end
            count <= count + CW'(pix_valid) - CW'(pop);
            case (state)
                fb_pkg::WR_IDLE: begin
                    if (count != '0) begin
                        state <= fb_pkg::WR_FIRST;
                    end
                end
                fb_pkg::WR_FIRST: begin
                    if (wr_gnt) begin
                        state <= fb_pkg::WR_SECOND;
                    end
                end
                fb_pkg::WR_SECOND: begin
                    if (wr_gnt) begin
                        state <= (count > CW'(1) || pix_valid) ? fb_pkg::WR_FIRST
                                                               : fb_pkg::WR_IDLE;
                    end
                end
                default: state <= fb_pkg::WR_IDLE;
            endcase
        end
    end

    // even ids start a word, odd ids share the middle word
    always_comb begin
        wr_addr = (state == fb_pkg::WR_SECOND) ? base + 1'b1 : base;
        case ({state == fb_pkg::WR_SECOND, cur.id[0]})
            2'b00: begin
                wr_data = {cur.color.red, cur.color.green};
                wr_be   = 2'b11;
            end
            2'b10: begin
                wr_data = {cur.color.blue, 8'h00};
                wr_be   = 2'b10;
            end
            2'b01: begin
                wr_data = {8'h00, cur.color.red};
                wr_be   = 2'b01;
            end
            default: begin
                wr_data = {cur.color.green, cur.color.blue};
                wr_be   = 2'b11;
            end
        endcase
    end

    // a pixel without a credit would land in a full queue
    assert property (@(posedge clk) disable iff (!arst_n)
        pix_valid |-> count < CW'(CREDITS));

    // request held steady while the reader owns the bus
    assert property (@(posedge clk) disable iff (!arst_n)
        wr_req && !wr_gnt |=> wr_req && $stable(wr_addr) && $stable(wr_data) &&
                              $stable(wr_be));

endmodule

// File: design/fb_pkg.sv
package fb_pkg;

    // one 24-bit pixel
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } color_t;

    // linear index, row * active width + column
    typedef logic [18:0] pixel_id_t;
    // sram halfword address and data word
    typedef logic [19:0] sram_addr_t;
    typedef logic [15:0] sram_word_t;
    typedef logic [9:0]  screen_pos_t;
    typedef logic [1:0]  cfg_addr_t;

    typedef struct packed {
        pixel_id_t id;
        color_t    color;
    } pixel_xfer_t;

    typedef enum logic [1:0] {
        SRC_FRAME   = 2'd0,
        SRC_STRIPES = 2'd1,
        SRC_SQUARE  = 2'd2
    } display_src_t;

    typedef struct packed {
        display_src_t src;
        screen_pos_t  sq_row;
        screen_pos_t  sq_col;
    } fb_cfg_t;

    // config register map
    localparam cfg_addr_t CFG_SRC    = 2'd0;
    localparam cfg_addr_t CFG_SQ_ROW = 2'd1;
    localparam cfg_addr_t CFG_SQ_COL = 2'd2;

    typedef enum logic [1:0] {WR_IDLE, WR_FIRST, WR_SECOND} wr_state_t;
    typedef enum logic [2:0] {F_IDLE, F_A, F_B, F_C, F_GAP} fetch_state_t;

endpackage

// File: design/fb_scan_reader.sv
module fb_scan_reader #(
    parameter int H_ACTIVE = 640,
    parameter int SQ_SIZE  = 32
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                pix_en,
    input  fb_pkg::screen_pos_t row,
    input  fb_pkg::screen_pos_t col,
    input  logic                active,
    input  logic                frame_start,
    input  fb_pkg::fb_cfg_t     cfg,
    input  fb_pkg::sram_word_t  rd_data,
    output logic                rd_req,
    output fb_pkg::sram_addr_t  rd_addr,
    output logic                de,
    output fb_pkg::color_t      rgb
);

    localparam fb_pkg::screen_pos_t LAST_GRP = fb_pkg::screen_pos_t'(H_ACTIVE / 2 - 1);
    localparam fb_pkg::screen_pos_t SQ       = fb_pkg::screen_pos_t'(SQ_SIZE);

    fb_pkg::fetch_state_t state;
    fb_pkg::screen_pos_t  grp;
    fb_pkg::sram_word_t   word_a;
    fb_pkg::sram_word_t   word_b;
    fb_pkg::sram_word_t   word_c;
    fb_pkg::color_t       pix_q;
    fb_pkg::color_t       stripe_px;
    logic                 run_line;
    logic                 line_start;
    logic                 in_sq;

    // first cycle of every line
    assign line_start = (col == '0) && !pix_en;
    assign rd_req     = (state == fb_pkg::F_A) || (state == fb_pkg::F_B) ||
                        (state == fb_pkg::F_C);

    // an active line fetches pairs 1..n-1 and then pair 0 of the next line,
    // a blanking line only prefetches pair 0 of the frame
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= fb_pkg::F_IDLE;
            run_line <= 1'b0;
            grp      <= '0;
            rd_addr  <= '0;
        end else begin
            if (frame_start) begin
                rd_addr <= fb_pkg::sram_addr_t'(3);
            end else if (line_start && !active) begin
                rd_addr <= '0;
            end else if (rd_req) begin
                rd_addr <= rd_addr + 1'b1;
            end
            case (state)
                fb_pkg::F_IDLE: begin
                    if (line_start) begin
                        state    <= fb_pkg::F_A;
                        run_line <= active;
                        grp      <= '0;
                    end
                end
                fb_pkg::F_A: state <= fb_pkg::F_B;
                fb_pkg::F_B: state <= fb_pkg::F_C;
                fb_pkg::F_C: state <= fb_pkg::F_GAP;
                fb_pkg::F_GAP: begin
                    if (!run_line || grp == LAST_GRP) begin
                        state <= fb_pkg::F_IDLE;
                    end else begin
                        state <= fb_pkg::F_A;
                        grp   <= grp + 1'b1;
                    end
                end
                default: state <= fb_pkg::F_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == fb_pkg::F_A) begin
            word_a <= rd_data;
        end
        if (state == fb_pkg::F_B) begin
            word_b <= rd_data;
        end
        if (state == fb_pkg::F_C) begin
            word_c <= rd_data;
        end
        // loads the pixel for the next column
        if (pix_en) begin
            pix_q <= col[0] ? {word_a, word_b[15:8]} : {word_b[7:0], word_c};
        end
    end

    assign stripe_px = {col[3], 7'b0, col[2], 7'b0, col[1], 7'b0};
    // unsigned wrap makes positions left of or above the square fail too
    assign in_sq = (fb_pkg::screen_pos_t'(row - cfg.sq_row) < SQ) &&
                   (fb_pkg::screen_pos_t'(col - cfg.sq_col) < SQ);

    always_comb begin
        case (cfg.src)
            fb_pkg::SRC_STRIPES: rgb = stripe_px;
            fb_pkg::SRC_SQUARE:  rgb = in_sq ? 24'hFFFFFF : 24'h000000;
            default:             rgb = pix_q;
        endcase
    end

    assign de = active;

    // reads stay inside the active line or the blanking prefetch slot
    assert property (@(posedge clk) disable iff (!arst_n)
        rd_req |-> active || col < fb_pkg::screen_pos_t'(2));

endmodule

// File: design/fb_sram_port.sv
module fb_sram_port (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               rd_req,
    input  fb_pkg::sram_addr_t rd_addr,
    input  logic               wr_req,
    input  fb_pkg::sram_addr_t wr_addr,
    input  fb_pkg::sram_word_t wr_data,
    input  logic [1:0]         wr_be,
    output logic               wr_gnt,
    output fb_pkg::sram_word_t rd_data,
    output fb_pkg::sram_addr_t sram_addr,
    output logic               sram_we_n,
    output logic               sram_oe_n,
    output logic               sram_ub_n,
    output logic               sram_lb_n,
    inout  wire fb_pkg::sram_word_t sram_dq
);

    // reader always wins
    assign wr_gnt    = wr_req && !rd_req;
    assign sram_addr = rd_req ? rd_addr : wr_addr;
    assign sram_oe_n = !rd_req;
    assign sram_we_n = !wr_gnt;
    assign sram_ub_n = !(rd_req || (wr_gnt && wr_be[1]));
    assign sram_lb_n = !(rd_req || (wr_gnt && wr_be[0]));

    assign sram_dq = wr_gnt ? wr_data : 'z;
    assign rd_data = sram_dq;

    assert property (@(posedge clk) disable iff (!arst_n)
        !(!sram_oe_n && !sram_we_n));

endmodule

// File: design/frame_buffer_top.sv
module frame_buffer_top #(
    parameter int H_ACTIVE = 640,
    parameter int H_TOTAL  = 800,
    parameter int V_ACTIVE = 480,
    parameter int V_TOTAL  = 525,
    parameter int H_SYNC   = 96,
    parameter int V_SYNC   = 2,
    parameter int CREDITS  = 4,
    parameter int SQ_SIZE  = 32
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                pix_valid,
    input  fb_pkg::pixel_xfer_t pix,
    input  logic                cfg_we,
    input  fb_pkg::cfg_addr_t   cfg_addr,
    input  fb_pkg::screen_pos_t cfg_wdata,
    output logic                pix_credit,
    output logic                hs,
    output logic                vs,
    output logic                de,
    output fb_pkg::color_t      rgb,
    output fb_pkg::sram_addr_t  sram_addr,
    output logic                sram_we_n,
    output logic                sram_oe_n,
    output logic                sram_ub_n,
    output logic                sram_lb_n,
    inout  wire fb_pkg::sram_word_t sram_dq
);

    logic                pix_en;
    logic                active;
    logic                frame_start;
    fb_pkg::screen_pos_t row;
    fb_pkg::screen_pos_t col;
    fb_pkg::fb_cfg_t     cfg;
    logic                rd_req;
    fb_pkg::sram_addr_t  rd_addr;
    fb_pkg::sram_word_t  rd_data;
    logic                wr_req;
    logic                wr_gnt;
    fb_pkg::sram_addr_t  wr_addr;
    fb_pkg::sram_word_t  wr_data;
    logic [1:0]          wr_be;

    video_timing #(
        .H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL), .V_ACTIVE(V_ACTIVE),
        .V_TOTAL(V_TOTAL), .H_SYNC(H_SYNC), .V_SYNC(V_SYNC)
    ) u_timing (
        .clk, .arst_n, .pix_en, .row, .col, .active, .frame_start, .hs, .vs
    );

    fb_config_regs u_cfg (
        .clk, .arst_n, .cfg_we, .cfg_addr, .cfg_wdata, .frame_start, .cfg
    );

    fb_scan_reader #(.H_ACTIVE(H_ACTIVE), .SQ_SIZE(SQ_SIZE)) u_reader (
        .clk, .arst_n, .pix_en, .row, .col, .active, .frame_start, .cfg,
        .rd_data, .rd_req, .rd_addr, .de, .rgb
    );

    fb_pixel_writer #(.H_ACTIVE(H_ACTIVE), .CREDITS(CREDITS)) u_writer (
        .clk, .arst_n, .pix_valid, .pix, .wr_gnt, .pix_credit,
        .wr_req, .wr_addr, .wr_data, .wr_be
    );

    fb_sram_port u_port (
        .clk, .arst_n, .rd_req, .rd_addr, .wr_req, .wr_addr, .wr_data, .wr_be,
        .wr_gnt, .rd_data, .sram_addr, .sram_we_n, .sram_oe_n, .sram_ub_n,
        .sram_lb_n, .sram_dq
    );

endmodule

// File: design/video_timing.sv
module video_timing #(
    parameter int H_ACTIVE = 640,
    parameter int H_TOTAL  = 800,
    parameter int V_ACTIVE = 480,
    parameter int V_TOTAL  = 525,
    parameter int H_SYNC   = 96,
    parameter int V_SYNC   = 2
) (
    input  logic                clk,
    input  logic                arst_n,
    output logic                pix_en,
    output fb_pkg::screen_pos_t row,
    output fb_pkg::screen_pos_t col,
    output logic                active,
    output logic                frame_start,
    output logic                hs,
    output logic                vs
);

    localparam fb_pkg::screen_pos_t H_LAST   = fb_pkg::screen_pos_t'(H_TOTAL - 1);
    localparam fb_pkg::screen_pos_t V_LAST   = fb_pkg::screen_pos_t'(V_TOTAL - 1);
    localparam fb_pkg::screen_pos_t H_ACT    = fb_pkg::screen_pos_t'(H_ACTIVE);
    localparam fb_pkg::screen_pos_t V_ACT    = fb_pkg::screen_pos_t'(V_ACTIVE);
    localparam fb_pkg::screen_pos_t HS_END   = fb_pkg::screen_pos_t'(H_ACTIVE + H_SYNC);
    localparam fb_pkg::screen_pos_t VS_END   = fb_pkg::screen_pos_t'(V_ACTIVE + V_SYNC);

    // start in the last blanking line so the first frame can be prefetched
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pix_en <= 1'b0;
            col    <= '0;
            row    <= V_LAST;
        end else begin
            pix_en <= !pix_en;
            if (pix_en) begin
                if (col == H_LAST) begin
                    col <= '0;
                    row <= (row == V_LAST) ? '0 : row + 1'b1;
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

    assign active      = (col < H_ACT) && (row < V_ACT);
    assign frame_start = !pix_en && (row == '0) && (col == '0);
    assign hs          = !((col >= H_ACT) && (col < HS_END));
    assign vs          = !((row >= V_ACT) && (row < VS_END));

endmodule

// File: dv/sram_model.sv
module sram_model #(
    parameter int ADDR_BITS = 20
) (
    input  fb_pkg::sram_addr_t      addr,
    input  logic                    we_n,
    input  logic                    oe_n,
    input  logic                    ub_n,
    input  logic                    lb_n,
    inout  wire fb_pkg::sram_word_t dq
);

    fb_pkg::sram_word_t mem [1 << ADDR_BITS];

    // bus state as last seen, and since when it has been held
    fb_pkg::sram_addr_t addr_q = '0;
    fb_pkg::sram_word_t dq_q   = '0;
    logic               we_n_q = 1'b1;
    logic               ub_n_q = 1'b1;
    logic               lb_n_q = 1'b1;
    time                t_q    = 0;

    // a write lands when its pulse ends, zero-width glitches never land
    always @(addr or we_n or ub_n or lb_n or dq) begin
        if (!we_n_q && $time > t_q) begin
            if (!ub_n_q) begin
                mem[addr_q[ADDR_BITS-1:0]][15:8] = dq_q[15:8];
            end
            if (!lb_n_q) begin
                mem[addr_q[ADDR_BITS-1:0]][7:0] = dq_q[7:0];
            end
        end
        addr_q = addr;
        dq_q   = dq;
        we_n_q = we_n;
        ub_n_q = ub_n;
        lb_n_q = lb_n;
        t_q    = $time;
    end

    // asynchronous read per byte lane
    assign dq[15:8] = (!oe_n && we_n && !ub_n) ? mem[addr[ADDR_BITS-1:0]][15:8] : 8'hzz;
    assign dq[7:0]  = (!oe_n && we_n && !lb_n) ? mem[addr[ADDR_BITS-1:0]][7:0] : 8'hzz;

endmodule

// File: dv/tb_frame_buffer.sv
module tb_frame_buffer;

    localparam int H_ACTIVE   = 16;
    localparam int H_TOTAL    = 24;
    localparam int V_ACTIVE   = 8;
    localparam int V_TOTAL    = 11;
    localparam int H_SYNC     = 4;
    localparam int V_SYNC     = 2;
    localparam int CREDITS    = 4;
    localparam int SQ_SIZE    = 4;
    localparam int NUM_PIX    = H_ACTIVE * V_ACTIVE;
    localparam int WAIT_LIMIT = 2000;

    logic                    clk;
    logic                    arst_n;
    logic                    pix_valid;
    fb_pkg::pixel_xfer_t     pix;
    logic                    cfg_we;
    fb_pkg::cfg_addr_t       cfg_addr;
    fb_pkg::screen_pos_t     cfg_wdata;
    logic                    pix_credit;
    logic                    hs;
    logic                    vs;
    logic                    de;
    fb_pkg::color_t          rgb;
    fb_pkg::sram_addr_t      sram_addr;
    logic                    sram_we_n;
    logic                    sram_oe_n;
    logic                    sram_ub_n;
    logic                    sram_lb_n;
    wire fb_pkg::sram_word_t sram_dq;

    // expected frame contents and config, as the testbench wrote them
    fb_pkg::color_t       exp_mem [NUM_PIX];
    fb_pkg::display_src_t mdl_src    = fb_pkg::SRC_FRAME;
    int                   mdl_sq_row = 0;
    int                   mdl_sq_col = 0;
    // config in force for the frame on screen
    fb_pkg::display_src_t frm_src    = fb_pkg::SRC_FRAME;
    int                   frm_sq_row = 0;
    int                   frm_sq_col = 0;

    logic [31:0] lfsr          = 32'd66784;
    logic        check_on      = 1'b0;
    int          credits       = CREDITS;
    int          de_cnt        = 0;
    int          frames_done   = 0;
    int          errors        = 0;
    int          errors_before = 0;
    int          checks        = 0;
    int          tests_run     = 0;
    int          tests_failed  = 0;

    frame_buffer_top #(
        .H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL), .V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL),
        .H_SYNC(H_SYNC), .V_SYNC(V_SYNC), .CREDITS(CREDITS), .SQ_SIZE(SQ_SIZE)
    ) uut (
        .clk, .arst_n, .pix_valid, .pix, .cfg_we, .cfg_addr, .cfg_wdata, .pix_credit,
        .hs, .vs, .de, .rgb, .sram_addr, .sram_we_n, .sram_oe_n, .sram_ub_n,
        .sram_lb_n, .sram_dq
    );

    sram_model #(.ADDR_BITS(8)) u_sram (
        .addr(sram_addr), .we_n(sram_we_n), .oe_n(sram_oe_n), .ub_n(sram_ub_n),
        .lb_n(sram_lb_n), .dq(sram_dq)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2;
            clk = !clk;
        end
    end

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    function automatic fb_pkg::color_t rand_color();
        logic [23:0] bits;
        bits = 24'(rand_bits(24));
        return bits;
    endfunction

    // expected rgb at one screen position
    function automatic fb_pkg::color_t ref_rgb(input int r, input int c,
                                               input fb_pkg::display_src_t src,
                                               input int sq_row, input int sq_col);
        fb_pkg::color_t px;
        case (src)
            fb_pkg::SRC_STRIPES: begin
                px.red   = c[3] ? 8'h80 : 8'h00;
                px.green = c[2] ? 8'h80 : 8'h00;
                px.blue  = c[1] ? 8'h80 : 8'h00;
            end
            fb_pkg::SRC_SQUARE: begin
                if (r >= sq_row && r < sq_row + SQ_SIZE && c >= sq_col && c < sq_col + SQ_SIZE) begin
                    px = 24'hFF_FFFF;
                end else begin
                    px = 24'h00_0000;
                end
            end
            default: px = exp_mem[r * H_ACTIVE + c];
        endcase
        return px;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout while waiting for %s at t=%0t", what, $time);
        $display("SOME TESTS FAILED");
        $finish;
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name,
                     errors - errors_before);
        end
        errors_before = errors;
    endtask

    // valid stays high between back-to-back calls
    task automatic send_pixel(input int id, input fb_pkg::color_t color);
        int guard;
        guard = 0;
        @(posedge clk);
        #1;
        pix_valid = 1'b0;
        while (credits == 0) begin
            guard++;
            if (guard > WAIT_LIMIT) begin
                abort_on_timeout("a pixel credit");
            end
            @(posedge clk);
            #1;
        end
        pix_valid = 1'b1;
        pix.id    = fb_pkg::pixel_id_t'(id);
        pix.color = color;
        credits--;
        exp_mem[id] = color;
    endtask

    task automatic end_stream();
        @(posedge clk);
        #1;
        pix_valid = 1'b0;
    endtask

    task automatic write_cfg(input fb_pkg::cfg_addr_t a, input int val);
        @(posedge clk);
        #1;
        cfg_we    = 1'b1;
        cfg_addr  = a;
        cfg_wdata = fb_pkg::screen_pos_t'(val);
        @(posedge clk);
        // staging register takes the value on this edge
        case (a)
            fb_pkg::CFG_SRC:    mdl_src    = fb_pkg::display_src_t'(val[1:0]);
            fb_pkg::CFG_SQ_ROW: mdl_sq_row = val;
            fb_pkg::CFG_SQ_COL: mdl_sq_col = val;
            default: ;
        endcase
        #1;
        cfg_we = 1'b0;
    endtask

    task automatic wait_credits_back();
        int guard;
        guard = 0;
        while (credits != CREDITS) begin
            guard++;
            if (guard > WAIT_LIMIT) begin
                abort_on_timeout("all credits to return");
            end
            @(negedge clk);
        end
    endtask

    task automatic wait_vs_low();
        int guard;
        guard = 0;
        while (vs !== 1'b0) begin
            guard++;
            if (guard > WAIT_LIMIT) begin
                abort_on_timeout("vertical sync");
            end
            @(negedge clk);
        end
    endtask

    // n de cycles into a frame that is on screen now
    task automatic wait_de_count(input int n);
        int guard;
        guard = 0;
        while (!(vs === 1'b1 && de_cnt >= n)) begin
            guard++;
            if (guard > WAIT_LIMIT) begin
                abort_on_timeout("active video");
            end
            @(negedge clk);
        end
    endtask

    task automatic wait_frames(input int n);
        int guard;
        int target;
        guard  = 0;
        target = frames_done + n;
        while (frames_done < target) begin
            guard++;
            if (guard > WAIT_LIMIT) begin
                abort_on_timeout("the end of a frame");
            end
            @(negedge clk);
        end
    endtask

    task automatic check_frames(input int n);
        check_on = 1'b1;
        wait_frames(n);
        check_on = 1'b0;
    endtask

    // two de cycles per pixel, counted from the start of each frame
    initial begin
        forever begin
            @(negedge clk);
            if (!vs) begin
                de_cnt = 0;
            end else if (de) begin
                if (de_cnt == 0) begin
                    frm_src    = mdl_src;
                    frm_sq_row = mdl_sq_row;
                    frm_sq_col = mdl_sq_col;
                end
                if (check_on) begin
                    check_value("rgb", rgb, ref_rgb(de_cnt / 2 / H_ACTIVE,
                        (de_cnt / 2) % H_ACTIVE, frm_src, frm_sq_row, frm_sq_col));
                end
                de_cnt++;
                if (de_cnt == 2 * NUM_PIX) begin
                    frames_done++;
                end
            end
        end
    end

    initial begin
        forever begin
            @(negedge clk);
            if (pix_credit === 1'b1) begin
                credits++;
                if (credits > CREDITS) begin
                    errors++;
                    $display("more credits returned than pixels sent at t=%0t", $time);
                end
            end
        end
    end

    initial begin
        int order [NUM_PIX];
        int j;
        int tmp;
        int guard;
        arst_n    = 1'b0;
        pix_valid = 1'b0;
        pix       = '0;
        cfg_we    = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;

        repeat (4) @(posedge clk);
        @(negedge clk);
        check_value("pix_credit", pix_credit, 0);
        check_value("de", de, 0);
        check_value("sram_we_n", sram_we_n, 1);
        check_value("sram_oe_n", sram_oe_n, 1);
        check_value("hs", hs, 1);
        check_value("vs", vs, 1);
        @(posedge clk);
        #1;
        arst_n = 1'b1;
        guard  = 0;
        while (de !== 1'b1) begin
            @(negedge clk);
            check_value("pix_credit", pix_credit, 0);
            check_value("sram_we_n", sram_we_n, 1);
            check_value("vs", vs, 1);
            guard++;
            if (guard > WAIT_LIMIT) begin
                abort_on_timeout("the first active pixel");
            end
        end
        report_test("idle after reset");

        for (int i = 0; i < NUM_PIX; i++) begin
            send_pixel(i, rand_color());
        end
        end_stream();
        wait_credits_back();
        wait_vs_low();
        check_frames(1);
        report_test("full frame in id order");

        for (int i = 0; i < NUM_PIX; i++) begin
            order[i] = i;
        end
        for (int i = NUM_PIX - 1; i > 0; i--) begin
            j        = rand_bits(8) % (i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < NUM_PIX; i++) begin
            send_pixel(order[i], rand_color());
        end
        // second writes to some ids
        for (int i = 0; i < 16; i++) begin
            j = rand_bits(7) % NUM_PIX;
            send_pixel(j, rand_color());
        end
        end_stream();
        wait_credits_back();
        wait_vs_low();
        check_frames(1);
        report_test("shuffled order with overwrites");

        wait_vs_low();
        check_on = 1'b1;
        wait_de_count(NUM_PIX);
        write_cfg(fb_pkg::CFG_SRC, fb_pkg::SRC_STRIPES);
        wait_frames(2);
        check_on = 1'b0;
        report_test("stripes switched mid-frame");

        write_cfg(fb_pkg::CFG_SQ_ROW, 2);
        write_cfg(fb_pkg::CFG_SQ_COL, 5);
        write_cfg(fb_pkg::CFG_SRC, fb_pkg::SRC_SQUARE);
        wait_vs_low();
        check_frames(1);
        report_test("square pattern");

        write_cfg(fb_pkg::CFG_SRC, fb_pkg::SRC_FRAME);
        wait_vs_low();
        wait_de_count(1);
        for (int i = 0; i < NUM_PIX; i++) begin
            send_pixel(i, rand_color());
        end
        end_stream();
        wait_credits_back();
        wait_vs_low();
        check_frames(1);
        report_test("streaming during active video");

        $display("%0d tests run, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
design/fb_pkg.sv
design/fb_pixel_writer.sv
design/fb_scan_reader.sv
design/video_timing.sv
design/fb_config_regs.sv
design/fb_sram_port.sv
design/frame_buffer_top.sv
dv/sram_model.sv
dv/tb_frame_buffer.sv
